// ==== axis_switch.sv ====
module axis_switch import noc_pkg::*; #(
    parameter int fifo_depth = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  flit_t [num_ports-1:0] in_flit,
    input  logic  [num_ports-1:0] in_valid,
    output logic  [num_ports-1:0] in_ready,
    output flit_t [num_ports-1:0] out_flit,
    output logic  [num_ports-1:0] out_valid,
    input  logic  [num_ports-1:0] out_ready
);

    flit_t [num_ports-1:0] head;
    logic  [num_ports-1:0] head_valid;
    logic  [num_ports-1:0] head_pop;
    logic  [num_ports-1:0] drop;

    // indexed [output][input]
    logic [num_ports-1:0] req   [num_ports];
    logic [num_ports-1:0] grant [num_ports];

    genvar p;

    generate
        for (p = 0; p < num_ports; p++) begin : g_in
            stream_fifo #(
                .payload_t(flit_t),
                .depth    (fifo_depth)
            ) u_in_fifo (
                .clk      (clk),
                .reset    (reset),
                .in_data  (in_flit[p]),
                .in_valid (in_valid[p]),
                .in_ready (in_ready[p]),
                .out_data (head[p]),
                .out_valid(head_valid[p]),
                .out_ready(head_pop[p])
            );

            // ports 6 and 7 have no output
            assign drop[p] = head_valid[p] && (head[p].dest[2:0] >= 3'(num_ports));
        end
    endgenerate

    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            for (int i = 0; i < num_ports; i++) begin
                req[o][i] = head_valid[i] && (head[i].dest[2:0] == 3'(o));
            end
        end
    end

    generate
        for (p = 0; p < num_ports; p++) begin : g_out
            rr_arbiter u_arb (
                .clk    (clk),
                .reset  (reset),
                .request(req[p]),
                .advance(out_valid[p] && out_ready[p]),
                .grant  (grant[p])
            );

            assign out_valid[p] = |grant[p];

            always_comb begin
                out_flit[p] = '0;
                for (int i = 0; i < num_ports; i++) begin
                    if (grant[p][i]) begin
                        out_flit[p] = head[i];
                    end
                end
            end
        end
    endgenerate

    // pop on output acceptance or on drop
    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            head_pop[i] = drop[i];
            for (int o = 0; o < num_ports; o++) begin
                if (grant[o][i] && out_ready[o]) begin
                    head_pop[i] = 1'b1;
                end
            end
        end
    end

endmodule

// ==== host_port.sv ====
module host_port import noc_pkg::*; #(
    parameter int fifo_depth = 2
) (
    input  logic  clk,
    input  logic  reset,
    input  flit_t in_flit,
    input  logic  in_valid,
    output logic  in_ready,
    output flit_t to_switch_flit,
    output logic  to_switch_valid,
    input  logic  to_switch_ready,
    input  flit_t from_switch_flit,
    input  logic  from_switch_valid,
    output logic  from_switch_ready,
    output flit_t out_flit,
    output logic  out_valid,
    input  logic  out_ready
);

    // ingress toward switch port 0
    stream_fifo #(
        .payload_t(flit_t),
        .depth    (fifo_depth)
    ) u_ingress (
        .clk      (clk),
        .reset    (reset),
        .in_data  (in_flit),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_data (to_switch_flit),
        .out_valid(to_switch_valid),
        .out_ready(to_switch_ready)
    );

    // egress from switch port 0
    stream_fifo #(
        .payload_t(flit_t),
        .depth    (fifo_depth)
    ) u_egress (
        .clk      (clk),
        .reset    (reset),
        .in_data  (from_switch_flit),
        .in_valid (from_switch_valid),
        .in_ready (from_switch_ready),
        .out_data (out_flit),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

// ==== mailbox_endpoint.sv ====
module mailbox_endpoint import noc_pkg::*; #(
    parameter int fifo_depth = 8
) (
    input  logic  clk,
    input  logic  reset,
    input  flit_t in_flit,
    input  logic  in_valid,
    output logic  in_ready,
    output flit_t out_flit,
    output logic  out_valid,
    input  logic  out_ready
);

    mail_t store_in;
    mail_t store_out;
    logic  store_in_valid;
    logic  store_in_ready;
    logic  store_out_valid;
    logic  store_out_ready;
    logic  is_read;
    logic  rd_accept;

    assign is_read = in_flit.dest[3];

    assign store_in.data = in_flit.data;
    assign store_in.id   = in_flit.id;

    // nothing is taken while a reply waits
    assign in_ready        = !out_valid && (is_read || store_in_ready);
    assign store_in_valid  = in_valid && !is_read && !out_valid;
    assign store_out_ready = in_valid && is_read && !out_valid;
    assign rd_accept       = in_valid && in_ready && is_read;

    stream_fifo #(
        .payload_t(mail_t),
        .depth    (fifo_depth)
    ) u_store (
        .clk      (clk),
        .reset    (reset),
        .in_data  (store_in),
        .in_valid (store_in_valid),
        .in_ready (store_in_ready),
        .out_data (store_out),
        .out_valid(store_out_valid),
        .out_ready(store_out_ready)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (rd_accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            out_flit.dest <= dest_t'(host_port_id);
            out_flit.last <= 1'b1;
            if (store_out_valid) begin
                out_flit.data <= store_out.data;
                out_flit.id   <= store_out.id;
            end else begin
                // empty read
                out_flit.data <= '0;
                out_flit.id   <= 2'd3;
            end
        end
    end

endmodule

// ==== noc_pkg.sv ====
package noc_pkg;

    // switch port map
    localparam int num_ports       = 6;
    localparam int host_port_id    = 0;
    localparam int mailbox_port_id = 5;

    // lane geometry
    localparam int lane_width = 32;
    localparam int num_lanes  = 4;

    typedef logic [lane_width-1:0] lane_t;
    typedef lane_t [num_lanes-1:0] data_t;

    // dest[2:0] selects the output port, dest[3] is the endpoint flag
    typedef logic [3:0] dest_t;
    typedef logic [1:0] id_t;

    typedef struct packed {
        data_t data;
        dest_t dest;
        id_t   id;
        logic  last;
    } flit_t;

    // one stored mailbox entry
    typedef struct packed {
        data_t data;
        id_t   id;
    } mail_t;

endpackage

// ==== pe_4_switch.f ====
noc_pkg.sv
stream_fifo.sv
rr_arbiter.sv
axis_switch.sv
pe_core.sv
host_port.sv
mailbox_endpoint.sv
pe_4_switch.sv
tb_pe_4_switch.sv

// ==== pe_4_switch.sv ====
module pe_4_switch import noc_pkg::*; #(
    parameter int switch_fifo_depth  = 4,
    parameter int host_fifo_depth    = 2,
    parameter int mailbox_fifo_depth = 8
) (
    input  logic  clk,
    input  logic  reset,
    input  flit_t in_flit,
    input  logic  in_valid,
    output logic  in_ready,
    output flit_t out_flit,
    output logic  out_valid,
    input  logic  out_ready
);

    flit_t [num_ports-1:0] sw_in_flit;
    logic  [num_ports-1:0] sw_in_valid;
    logic  [num_ports-1:0] sw_in_ready;
    flit_t [num_ports-1:0] sw_out_flit;
    logic  [num_ports-1:0] sw_out_valid;
    logic  [num_ports-1:0] sw_out_ready;

    axis_switch #(
        .fifo_depth(switch_fifo_depth)
    ) u_switch (
        .clk      (clk),
        .reset    (reset),
        .in_flit  (sw_in_flit),
        .in_valid (sw_in_valid),
        .in_ready (sw_in_ready),
        .out_flit (sw_out_flit),
        .out_valid(sw_out_valid),
        .out_ready(sw_out_ready)
    );

    host_port #(
        .fifo_depth(host_fifo_depth)
    ) u_host (
        .clk              (clk),
        .reset            (reset),
        .in_flit          (in_flit),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .to_switch_flit   (sw_in_flit[host_port_id]),
        .to_switch_valid  (sw_in_valid[host_port_id]),
        .to_switch_ready  (sw_in_ready[host_port_id]),
        .from_switch_flit (sw_out_flit[host_port_id]),
        .from_switch_valid(sw_out_valid[host_port_id]),
        .from_switch_ready(sw_out_ready[host_port_id]),
        .out_flit         (out_flit),
        .out_valid        (out_valid),
        .out_ready        (out_ready)
    );

    // pe n sits on switch port n+1
    genvar g;

    generate
        for (g = 0; g < 4; g++) begin : g_pe
            pe_core #(
                .pe_index(g)
            ) u_pe (
                .clk      (clk),
                .reset    (reset),
                .in_flit  (sw_out_flit[g+1]),
                .in_valid (sw_out_valid[g+1]),
                .in_ready (sw_out_ready[g+1]),
                .out_flit (sw_in_flit[g+1]),
                .out_valid(sw_in_valid[g+1]),
                .out_ready(sw_in_ready[g+1])
            );
        end
    endgenerate

    mailbox_endpoint #(
        .fifo_depth(mailbox_fifo_depth)
    ) u_mailbox (
        .clk      (clk),
        .reset    (reset),
        .in_flit  (sw_out_flit[mailbox_port_id]),
        .in_valid (sw_out_valid[mailbox_port_id]),
        .in_ready (sw_out_ready[mailbox_port_id]),
        .out_flit (sw_in_flit[mailbox_port_id]),
        .out_valid(sw_in_valid[mailbox_port_id]),
        .out_ready(sw_in_ready[mailbox_port_id])
    );

endmodule

// ==== pe_core.sv ====
module pe_core import noc_pkg::*; #(
    parameter int pe_index = 0
) (
    input  logic  clk,
    input  logic  reset,
    input  flit_t in_flit,
    input  logic  in_valid,
    output logic  in_ready,
    output flit_t out_flit,
    output logic  out_valid,
    input  logic  out_ready
);

    data_t acc;
    data_t sum;
    logic  accept;

    // lane-wise add, wraps mod 2^32
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            sum[l] = acc[l] + in_flit.data[l];
        end
    end

    // one reply in flight at a time
    assign in_ready = !out_valid;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc       <= '0;
            out_valid <= 1'b0;
        end else if (accept) begin
            acc       <= sum;
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_flit.data <= sum;
            out_flit.id   <= id_t'(pe_index);
            out_flit.last <= in_flit.last;
            // flag picks mailbox over host
            if (in_flit.dest[3]) begin
                out_flit.dest <= dest_t'(mailbox_port_id);
            end else begin
                out_flit.dest <= dest_t'(host_port_id);
            end
        end
    end

endmodule

// ==== rr_arbiter.sv ====
module rr_arbiter import noc_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [num_ports-1:0] request,
    input  logic                 advance,
    output logic [num_ports-1:0] grant
);

    localparam int ptr_w = $clog2(num_ports);

    logic [ptr_w-1:0]     ptr;
    logic [ptr_w-1:0]     win;
    logic [num_ports-1:0] pick;
    logic [num_ports-1:0] held;
    logic                 locked;

    // first requester at or after the pointer
    always_comb begin
        int   idx;
        logic found;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < num_ports; i++) begin
            idx = (int'(ptr) + i) % num_ports;
            if (!found && request[idx]) begin
                pick[idx] = 1'b1;
                found     = 1'b1;
            end
        end
    end

    // keep the grant stable until the output takes the flit
    assign grant = locked ? held : pick;

    always_comb begin
        win = '0;
        for (int i = 0; i < num_ports; i++) begin
            if (grant[i]) begin
                win = ptr_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr    <= '0;
            locked <= 1'b0;
            held   <= '0;
        end else begin
            locked <= (|grant) && !advance;
            held   <= grant;
            if (advance) begin
                ptr <= (win == ptr_w'(num_ports - 1)) ? '0 : win + 1'b1;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the tile testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_pe_4_switch \
    -f pe_4_switch.f -o tb_pe_4_switch
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/tb_pe_4_switch
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0

// ==== stream_fifo.sv ====
module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    // a full fifo still takes a new item when the head leaves this cycle
    assign in_ready = (count != cnt_w'(depth)) || out_ready;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== tb_pe_4_switch.sv ====
module tb_pe_4_switch import noc_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 200;
    localparam int quiet_cycles   = 50;

    logic  clk;
    logic  reset;
    flit_t in_flit;
    logic  in_valid;
    logic  in_ready;
    flit_t out_flit;
    logic  out_valid;
    logic  out_ready;

    // reference model state
    lane_t acc_model [4][num_lanes];
    mail_t mail_model [$];

    // flits taken at the tile output
    flit_t rx_q [$];

    pe_4_switch #(
        .switch_fifo_depth (4),
        .host_fifo_depth   (2),
        .mailbox_fifo_depth(8)
    ) dut (
        .clk      (clk),
        .reset    (reset),
        .in_flit  (in_flit),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_flit (out_flit),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    always #20 clk = ~clk;

    // capture each output transfer mid-cycle
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            rx_q.push_back(out_flit);
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_equal(input logic [$bits(flit_t)-1:0] actual,
                               input logic [$bits(flit_t)-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0d ns: %s, got %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    function automatic flit_t make_flit(input int port, input logic flag, input logic last);
        flit_t f;
        for (int l = 0; l < num_lanes; l++) begin
            f.data[l] = $urandom;
        end
        f.dest = {flag, 3'(port)};
        f.id   = 2'd0;
        f.last = last;
        return f;
    endfunction

    // lane-wise sums with the reply sent to host or mailbox
    function automatic flit_t pe_model(input int pe, input flit_t f);
        flit_t r;
        for (int l = 0; l < num_lanes; l++) begin
            acc_model[pe][l] = acc_model[pe][l] + f.data[l];
            r.data[l]        = acc_model[pe][l];
        end
        r.dest = f.dest[3] ? dest_t'(mailbox_port_id) : dest_t'(host_port_id);
        r.id   = id_t'(pe);
        r.last = f.last;
        return r;
    endfunction

    function automatic void mail_write_model(input flit_t f);
        mail_t m;
        m.data = f.data;
        m.id   = f.id;
        mail_model.push_back(m);
    endfunction

    function automatic flit_t mail_read_model();
        flit_t r;
        mail_t m;
        r.dest = dest_t'(host_port_id);
        r.last = 1'b1;
        if (mail_model.size() > 0) begin
            m      = mail_model.pop_front();
            r.data = m.data;
            r.id   = m.id;
        end else begin
            r.data = '0;
            r.id   = 2'd3;
        end
        return r;
    endfunction

    task automatic send_flit(input flit_t f);
        int   waited;
        logic taken;
        waited   = 0;
        taken    = 1'b0;
        in_flit  = f;
        in_valid = 1'b1;
        while (!taken) begin
            if (waited == timeout_cycles) begin
                fail_run("input flit was not accepted within 200 cycles");
            end
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #2;
            waited++;
        end
        in_valid = 1'b0;
    endtask

    task automatic expect_flit(output flit_t f);
        int waited;
        waited = 0;
        while (rx_q.size() == 0) begin
            if (waited == timeout_cycles) begin
                fail_run("no output flit arrived within 200 cycles");
            end
            @(posedge clk);
            #2;
            waited++;
        end
        f = rx_q.pop_front();
    endtask

    task automatic expect_quiet(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            if (rx_q.size() != 0) begin
                fail_run("an output flit appeared where none was expected");
            end
            @(posedge clk);
            #2;
        end
    endtask

    // a stalled output keeps its flit until taken
    task automatic expect_held(input int cycles);
        flit_t held;
        int    waited;
        waited = 0;
        while (!out_valid) begin
            if (waited == timeout_cycles) begin
                fail_run("no output flit became valid within 200 cycles");
            end
            @(posedge clk);
            #2;
            waited++;
        end
        held = out_flit;
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk);
            #2;
            if (!out_valid) begin
                fail_run("output valid dropped while the output was stalled");
            end
            check_equal(out_flit, held, "stalled output flit");
        end
    endtask

    task automatic pe_accumulate();
        flit_t f;
        flit_t exp;
        flit_t got;
        for (int pe = 0; pe < 4; pe++) begin
            f   = make_flit(pe + 1, 1'b0, 1'($urandom));
            exp = pe_model(pe, f);
            send_flit(f);
            expect_flit(got);
            check_equal(got, exp, $sformatf("pe %0d first reply", pe));
        end
    endtask

    task automatic pe_wrap();
        flit_t f;
        flit_t exp;
        flit_t got;
        for (int pe = 0; pe < 4; pe++) begin
            f = make_flit(pe + 1, 1'b0, 1'b1);
            // lane 0 overflows on purpose
            f.data[0] = ~acc_model[pe][0] + 32'h10;
            exp       = pe_model(pe, f);
            send_flit(f);
            expect_flit(got);
            check_equal(got, exp, $sformatf("pe %0d running sum", pe));
        end
    endtask

    task automatic mailbox_forward();
        flit_t f;
        flit_t exp;
        flit_t got;
        f   = make_flit(3, 1'b1, 1'b0);
        exp = pe_model(2, f);
        mail_write_model(exp);
        send_flit(f);
        expect_quiet(quiet_cycles);
        send_flit(make_flit(mailbox_port_id, 1'b1, 1'b0));
        expect_flit(got);
        check_equal(got, mail_read_model(), "mailbox read of pe 2 reply");
    endtask

    task automatic mailbox_order();
        flit_t f;
        flit_t got;
        for (int n = 1; n <= 2; n++) begin
            f    = make_flit(mailbox_port_id, 1'b0, 1'b0);
            f.id = id_t'(n);
            mail_write_model(f);
            send_flit(f);
        end
        for (int n = 0; n < 3; n++) begin
            send_flit(make_flit(mailbox_port_id, 1'b1, 1'b0));
            expect_flit(got);
            check_equal(got, mail_read_model(), $sformatf("mailbox read %0d", n));
        end
    endtask

    task automatic output_backpressure();
        flit_t      f;
        flit_t      got;
        flit_t      exp [4];
        logic [3:0] seen;
        out_ready = 1'b0;
        for (int pe = 0; pe < 4; pe++) begin
            f       = make_flit(pe + 1, 1'b0, 1'($urandom));
            exp[pe] = pe_model(pe, f);
            send_flit(f);
        end
        expect_held(20);
        out_ready = 1'b1;
        seen      = '0;
        for (int n = 0; n < 4; n++) begin
            expect_flit(got);
            if (seen[got.id]) begin
                fail_run($sformatf("reply from pe %0d arrived twice", got.id));
            end
            seen[got.id] = 1'b1;
            check_equal(got, exp[got.id], $sformatf("stalled reply from pe %0d", got.id));
        end
        expect_quiet(20);
    endtask

    task automatic unused_port_drop();
        flit_t f;
        flit_t exp;
        flit_t got;
        send_flit(make_flit(6, 1'b0, 1'b0));
        expect_quiet(quiet_cycles);
        f   = make_flit(1, 1'b0, 1'b1);
        exp = pe_model(0, f);
        send_flit(f);
        expect_flit(got);
        check_equal(got, exp, "pe 0 reply after dropped flit");
    endtask

    initial begin
        void'($urandom(32'hce4b));
        clk       = 1'b0;
        reset     = 1'b1;
        in_flit   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        for (int pe = 0; pe < 4; pe++) begin
            for (int l = 0; l < num_lanes; l++) begin
                acc_model[pe][l] = '0;
            end
        end
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        pe_accumulate();
        pe_wrap();
        mailbox_forward();
        mailbox_order();
        output_backpressure();
        unused_port_drop();

        $display("TEST PASS");
        $finish;
    end

endmodule
